// File: source/apb_pkg.sv
package apb_pkg;

	//////////////////////////////////////////////////
	// Bus widths

	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;

	//////////////////////////////////////////////////
	// Address window of the bridge

	localparam logic [addr_width-1:0] base_addr = 32'h4000_0000;
	localparam int block_size = 32'h0000_0800;
	localparam int num_ports = 2;

	// Offset bits inside one peripheral block
	localparam int block_bits = $clog2(block_size);
	localparam int index_bits = $clog2(num_ports);
	localparam int tag_bits = addr_width - block_bits - index_bits;

	// Upper address bits that must match for a hit in the window
	localparam logic [tag_bits-1:0] base_tag = base_addr[addr_width-1 -: tag_bits];

	// Device index of each peripheral on the bridge
	localparam int ram_port = 0;
	localparam int mbox_port = 1;

	//////////////////////////////////////////////////
	// Peripheral sizes

	localparam int ram_words = 4;
	localparam int ram_index_bits = $clog2(ram_words);
	localparam int ram_byte_bits = $clog2(strb_width);
	// Offsets at or above 1 << ram_span_bits fall outside the RAM
	localparam int ram_span_bits = ram_index_bits + ram_byte_bits;

	localparam int fifo_depth = 4;
	localparam int fifo_ptr_bits = $clog2(fifo_depth);

	// Mailbox register map
	localparam logic [block_bits-1:0] mbox_data_off = 'h000;
	localparam logic [block_bits-1:0] mbox_count_off = 'h004;

	//////////////////////////////////////////////////
	// Bus types

	// One address word, seen flat or split into window fields
	typedef union packed {
		logic [addr_width-1:0] word;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [index_bits-1:0] devid;
			logic [block_bits-1:0] offset;
		} dec;
	} apb_addr_u;

	// Requester side of a link
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_u paddr;
		logic [data_width-1:0] pwdata;
		logic [strb_width-1:0] pstrb;
		logic [2:0] pprot;
	} apb_req_t;

	// Completer side of a link
	typedef struct packed {
		logic pready;
		logic [data_width-1:0] prdata;
		logic pslverr;
	} apb_rsp_t;

endpackage

// File: source/apb_req_slice.sv
`timescale 1ns/1ps

module apb_req_slice import apb_pkg::*; (
	input logic pclk,
	input logic arst_n,
	input apb_req_t up_req,
	output apb_rsp_t up_rsp,
	output apb_req_t mid_req,
	input apb_rsp_t mid_rsp
);

	//////////////////////////////////////////////////
	// Downstream sequencer

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_t;

	state_t state;

	// Captured copy of the upstream request
	apb_req_t req_q;

	// Registered response back to the upstream port
	logic rsp_ready_q;
	logic rsp_err_q;
	logic [data_width-1:0] rsp_data_q;

	logic up_start;
	logic mid_done;

	// Upstream setup phase seen while nothing is in flight
	// Pending response cycle blocks a new capture
	assign up_start = (state == st_idle) && up_req.psel && !up_req.penable && !rsp_ready_q;

	// Downstream completer finished the access
	assign mid_done = (state == st_access) && mid_rsp.pready;

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			rsp_ready_q <= 1'b0;
		end else begin
			// Upstream pready is a one cycle pulse after the downstream finish
			rsp_ready_q <= mid_done;
			case (state)
				st_idle: begin
					if (up_start)
						state <= st_setup;
				end
				st_setup: begin
					state <= st_access;
				end
				st_access: begin
					// Wait states simply hold us here
					if (mid_done)
						state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Payload registers

	always_ff @(posedge pclk) begin
		if (up_start)
			req_q <= up_req;
		if (mid_done) begin
			rsp_data_q <= mid_rsp.prdata;
			rsp_err_q <= mid_rsp.pslverr;
		end
	end

	// Replay the captured request with our own phase bits
	always_comb begin
		mid_req = req_q;
		mid_req.psel = (state != st_idle);
		mid_req.penable = (state == st_access);
	end

	always_comb begin
		up_rsp.pready = rsp_ready_q;
		up_rsp.prdata = rsp_data_q;
		up_rsp.pslverr = rsp_err_q;
	end

endmodule

// File: source/apb_bridge.sv
`timescale 1ns/1ps

module apb_bridge import apb_pkg::*; (
	input apb_req_t mid_req,
	output apb_rsp_t mid_rsp,
	output apb_req_t dev_req [num_ports],
	input apb_rsp_t dev_rsp [num_ports]
);

	//////////////////////////////////////////////////
	// Address decoding

	logic [tag_bits-1:0] tag;
	logic [index_bits-1:0] devid;
	logic win_match;

	always_comb begin
		tag = mid_req.paddr.dec.tag;
		devid = mid_req.paddr.dec.devid;

		// Upper bits have to land inside the bridge window
		// Every index value inside the window names a port
		win_match = (tag == base_tag);
	end

	//////////////////////////////////////////////////
	// Request fan-out

	always_comb begin
		for (int i = 0; i < num_ports; i++) begin
			// Shared control and data go to every port unchanged
			dev_req[i] = mid_req;

			// Peripherals only see the offset inside their own block
			dev_req[i].paddr.word = addr_width'(mid_req.paddr.dec.offset);

			// Only the addressed port gets psel
			dev_req[i].psel = mid_req.psel && win_match && (int'(devid) == i);
		end
	end

	//////////////////////////////////////////////////
	// Response mux

	always_comb begin
		// Idle bus returns all zeros
		mid_rsp = '0;

		if (mid_req.psel) begin
			if (win_match) begin
				// Forward the selected peripheral
				mid_rsp = dev_rsp[devid];
			end else begin
				// Nobody owns this address
				// Answer in the first access cycle with an error so the bus never hangs
				mid_rsp.pready = mid_req.penable;
				mid_rsp.pslverr = mid_req.penable;
			end
		end
	end

endmodule

// File: source/apb_scratch_ram.sv
`timescale 1ns/1ps

module apb_scratch_ram import apb_pkg::*; (
	input logic pclk,
	input logic arst_n,
	input apb_req_t req,
	output apb_rsp_t rsp
);

	//////////////////////////////////////////////////
	// Decode

	logic [data_width-1:0] mem [ram_words];

	logic [ram_index_bits-1:0] word_idx;
	logic in_range;
	logic access;
	logic wait_q;
	logic done;

	// Word select from the byte offset
	assign word_idx = req.paddr.dec.offset[ram_byte_bits +: ram_index_bits];

	// Anything above the last word is an error
	assign in_range = (req.paddr.dec.offset[block_bits-1:ram_span_bits] == '0);

	assign access = req.psel && req.penable;

	// Complete in the second access cycle
	assign done = access && wait_q;

	//////////////////////////////////////////////////
	// Wait state

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			wait_q <= 1'b0;
		end else begin
			// Set in first access cycle, clear once the transfer completes
			wait_q <= access && !wait_q;
		end
	end

	//////////////////////////////////////////////////
	// Storage

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int w = 0; w < ram_words; w++)
				mem[w] <= '0;
		end else if (done && req.pwrite && in_range) begin
			// Byte lanes without a strobe keep their old contents
			for (int b = 0; b < strb_width; b++) begin
				if (req.pstrb[b])
					mem[word_idx][8*b +: 8] <= req.pwdata[8*b +: 8];
			end
		end
	end

	//////////////////////////////////////////////////
	// Response

	always_comb begin
		rsp.pready = done;
		rsp.prdata = (done && !req.pwrite && in_range) ? mem[word_idx] : '0;
		rsp.pslverr = done && !in_range;
	end

endmodule

// File: source/apb_mailbox.sv
`timescale 1ns/1ps

module apb_mailbox import apb_pkg::*; (
	input logic pclk,
	input logic arst_n,
	input apb_req_t req,
	output apb_rsp_t rsp
);

	//////////////////////////////////////////////////
	// FIFO state

	logic [data_width-1:0] fifo [fifo_depth];

	logic [fifo_ptr_bits-1:0] wr_ptr;
	logic [fifo_ptr_bits-1:0] rd_ptr;
	logic [fifo_ptr_bits:0] count;

	logic full;
	logic empty;

	assign full = (count == (fifo_ptr_bits+1)'(fifo_depth));
	assign empty = (count == '0);

	//////////////////////////////////////////////////
	// Access decode

	logic access;
	logic is_data;
	logic is_count;
	logic push;
	logic pop;
	logic cnt_rd;
	logic err;

	// No wait states, every access ends in its first cycle
	assign access = req.psel && req.penable;

	assign is_data = (req.paddr.dec.offset == mbox_data_off);
	assign is_count = (req.paddr.dec.offset == mbox_count_off);

	// Data register pushes on write and pops on read
	assign push = access && is_data && req.pwrite && !full;
	assign pop = access && is_data && !req.pwrite && !empty;

	// Count register is read only
	assign cnt_rd = access && is_count && !req.pwrite;

	// Push when full, pop when empty, count writes and unmapped offsets
	assign err = access && !(push || pop || cnt_rd);

	//////////////////////////////////////////////////
	// Pointers and fill level

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == fifo_ptr_bits'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
				count <= count + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == fifo_ptr_bits'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
				count <= count - 1'b1;
			end
		end
	end

	// Entry storage
	always_ff @(posedge pclk) begin
		if (push)
			fifo[wr_ptr] <= req.pwdata;
	end

	//////////////////////////////////////////////////
	// Response

	always_comb begin
		rsp.pready = access;
		rsp.pslverr = err;
		if (pop)
			rsp.prdata = fifo[rd_ptr];
		else if (cnt_rd)
			rsp.prdata = data_width'(count);
		else
			rsp.prdata = '0;
	end

endmodule

// File: source/apb_subsys_top.sv
`timescale 1ns/1ps

module apb_subsys_top import apb_pkg::*; (
	input logic pclk,
	input logic arst_n,
	input apb_req_t up_req,
	output apb_rsp_t up_rsp
);

	//////////////////////////////////////////////////
	// Internal links

	// Slice to bridge
	apb_req_t mid_req;
	apb_rsp_t mid_rsp;

	// Bridge to peripherals
	apb_req_t dev_req [num_ports];
	apb_rsp_t dev_rsp [num_ports];

	//////////////////////////////////////////////////
	// Register slice on the upstream port

	apb_req_slice u_slice (
		.pclk(pclk),
		.arst_n(arst_n),
		.up_req(up_req),
		.up_rsp(up_rsp),
		.mid_req(mid_req),
		.mid_rsp(mid_rsp)
	);

	//////////////////////////////////////////////////
	// Address decode

	apb_bridge u_bridge (
		.mid_req(mid_req),
		.mid_rsp(mid_rsp),
		.dev_req(dev_req),
		.dev_rsp(dev_rsp)
	);

	//////////////////////////////////////////////////
	// Peripherals

	// Block 0 scratch RAM
	apb_scratch_ram u_ram (
		.pclk(pclk),
		.arst_n(arst_n),
		.req(dev_req[ram_port]),
		.rsp(dev_rsp[ram_port])
	);

	// Block 1 mailbox
	apb_mailbox u_mbox (
		.pclk(pclk),
		.arst_n(arst_n),
		.req(dev_req[mbox_port]),
		.rsp(dev_rsp[mbox_port])
	);

endmodule

// File: bench/apb_subsys_properties.sv
`timescale 1ns/1ps

module apb_subsys_properties import apb_pkg::*; (
	input logic pclk,
	input logic arst_n,
	input apb_req_t up_req,
	input apb_rsp_t up_rsp,
	input apb_req_t mid_req,
	input apb_rsp_t mid_rsp,
	input apb_req_t dev_req [num_ports]
);

	// Failures so far, watched by the testbench
	int fail_count = 0;

	// Collected psel of every bridge port
	logic [num_ports-1:0] dev_psel;

	always_comb begin
		for (int i = 0; i < num_ports; i++)
			dev_psel[i] = dev_req[i].psel;
	end

	//////////////////////////////////////////////////
	// Upstream port

	// pready only while the requester sits in access
	a_ready_in_access: assert property (@(posedge pclk) disable iff (!arst_n)
		up_rsp.pready |-> up_req.psel && up_req.penable)
	else begin
		$error("upstream pready outside an access phase");
		fail_count++;
	end

	// No response pulse while reset holds
	a_ready_in_reset: assert property (@(posedge pclk)
		!arst_n |-> !up_rsp.pready)
	else begin
		$error("upstream pready high during reset");
		fail_count++;
	end

	//////////////////////////////////////////////////
	// Slice to bridge link

	// Error flag comes with the completing cycle only
	a_err_with_ready: assert property (@(posedge pclk) disable iff (!arst_n)
		mid_rsp.pslverr |-> mid_rsp.pready)
	else begin
		$error("pslverr without pready on the bridge link");
		fail_count++;
	end

	// Request held until the completer answers
	a_mid_stable: assert property (@(posedge pclk) disable iff (!arst_n)
		mid_req.psel && !mid_rsp.pready |=> mid_req.psel
			&& $stable({mid_req.pwrite, mid_req.paddr, mid_req.pwdata})
			&& $stable({mid_req.pstrb, mid_req.pprot}))
	else begin
		$error("bridge link request changed before pready");
		fail_count++;
	end

	// At most one peripheral selected
	a_psel_onehot: assert property (@(posedge pclk) disable iff (!arst_n)
		$onehot0(dev_psel))
	else begin
		$error("more than one peripheral selected");
		fail_count++;
	end

endmodule

bind apb_subsys_top apb_subsys_properties u_props (
	.pclk(pclk),
	.arst_n(arst_n),
	.up_req(up_req),
	.up_rsp(up_rsp),
	.mid_req(mid_req),
	.mid_rsp(mid_rsp),
	.dev_req(dev_req)
);

// File: bench/apb_subsys_tb.sv
`timescale 1ns/1ps

module apb_subsys_tb import apb_pkg::*; ();

	localparam int clk_period = 20;
	localparam int reset_cycles = 8;
	localparam int num_directed = 34;
	localparam int num_random = 200;
	localparam int cycles_per_xfer = 200;

	localparam logic [addr_width-1:0] ram_base = base_addr + ram_port * block_size;
	localparam logic [addr_width-1:0] mbox_base = base_addr + mbox_port * block_size;
	// Well above the bridge window
	localparam logic [addr_width-1:0] outside_addr = 32'h5000_0000;

	logic pclk;
	logic arst_n;
	apb_req_t up_req;
	apb_rsp_t up_rsp;

	// Reference model of both peripherals
	logic [data_width-1:0] ram_model [ram_words];
	logic [data_width-1:0] mbox_model [$];

	apb_subsys_top dut (
		.pclk(pclk),
		.arst_n(arst_n),
		.up_req(up_req),
		.up_rsp(up_rsp)
	);

	initial begin
		pclk = 1'b0;
		forever #(clk_period / 2) pclk = ~pclk;
	end

	//////////////////////////////////////////////////
	// Failure handling

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic expect_rsp(input string what, input logic err, input logic exp_err,
			input logic check_data, input logic [data_width-1:0] data,
			input logic [data_width-1:0] exp_data);
		assert (err === exp_err && (!check_data || data === exp_data))
		else report_failure($sformatf("error at %0t: %s gave data %h err %b, expected %h err %b",
			$time, what, data, err, exp_data, exp_err));
	endtask

	// Bound protocol checker counts its own failures
	always @(posedge pclk) begin
		if (dut.u_props.fail_count != 0)
			report_failure($sformatf("error at %0t: a bound protocol assertion failed", $time));
	end

	initial begin
		repeat (reset_cycles + (num_directed + num_random) * cycles_per_xfer) @(posedge pclk);
		report_failure("timeout: a transfer never completed before the watchdog expired");
	end

	//////////////////////////////////////////////////
	// APB requester

	task automatic apb_transfer(input logic write, input logic [addr_width-1:0] addr,
			input logic [data_width-1:0] wdata, input logic [strb_width-1:0] strb,
			output logic [data_width-1:0] rdata, output logic err);
		// Setup phase
		@(negedge pclk);
		up_req.psel = 1'b1;
		up_req.penable = 1'b0;
		up_req.pwrite = write;
		up_req.paddr.word = addr;
		up_req.pwdata = write ? wdata : '0;
		up_req.pstrb = write ? strb : '0;
		up_req.pprot = 3'b000;
		// Access phase held until pready
		@(negedge pclk);
		up_req.penable = 1'b1;
		do
			@(negedge pclk);
		while (!up_rsp.pready);
		rdata = up_rsp.prdata;
		err = up_rsp.pslverr;
		// Hold across the completing edge, then idle
		@(negedge pclk);
		up_req = '0;
	endtask

	task automatic apb_write(input logic [addr_width-1:0] addr,
			input logic [data_width-1:0] data, input logic [strb_width-1:0] strb,
			output logic err);
		logic [data_width-1:0] unused;
		apb_transfer(1'b1, addr, data, strb, unused, err);
	endtask

	task automatic apb_read(input logic [addr_width-1:0] addr,
			output logic [data_width-1:0] data, output logic err);
		apb_transfer(1'b0, addr, '0, '0, data, err);
	endtask

	//////////////////////////////////////////////////
	// Checked operations against the model

	task automatic ram_write_check(input int idx, input logic [data_width-1:0] data,
			input logic [strb_width-1:0] strb);
		logic err;
		apb_write(ram_base + 4 * idx, data, strb, err);
		// Only strobed byte lanes take the new data
		for (int b = 0; b < strb_width; b++)
			if (strb[b])
				ram_model[idx][8*b +: 8] = data[8*b +: 8];
		expect_rsp("ram write", err, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic ram_read_check(input int idx);
		logic [data_width-1:0] data;
		logic err;
		apb_read(ram_base + 4 * idx, data, err);
		expect_rsp("ram read", err, 1'b0, 1'b1, data, ram_model[idx]);
	endtask

	task automatic mbox_push_check(input logic [data_width-1:0] data);
		logic err;
		logic exp_err;
		exp_err = (mbox_model.size() == fifo_depth);
		apb_write(mbox_base + mbox_data_off, data, '1, err);
		if (!exp_err)
			mbox_model.push_back(data);
		expect_rsp("mailbox push", err, exp_err, 1'b0, '0, '0);
	endtask

	task automatic mbox_pop_check();
		logic [data_width-1:0] data;
		logic [data_width-1:0] exp_data;
		logic err;
		logic exp_err;
		exp_err = (mbox_model.size() == 0);
		exp_data = '0;
		if (!exp_err)
			exp_data = mbox_model.pop_front();
		apb_read(mbox_base + mbox_data_off, data, err);
		expect_rsp("mailbox pop", err, exp_err, !exp_err, data, exp_data);
	endtask

	task automatic mbox_count_check();
		logic [data_width-1:0] data;
		logic err;
		apb_read(mbox_base + mbox_count_off, data, err);
		expect_rsp("mailbox count", err, 1'b0, 1'b1, data, mbox_model.size());
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [data_width-1:0] data;
		logic err;
		void'($urandom(32'h5375_34ab));
		arst_n = 1'b0;
		up_req = '0;
		foreach (ram_model[i])
			ram_model[i] = '0;
		repeat (reset_cycles) @(posedge pclk);
		@(negedge pclk);
		arst_n = 1'b1;

		// Cleared state straight after reset
		for (int i = 0; i < ram_words; i++)
			ram_read_check(i);
		mbox_count_check();

		// Every RAM word, random byte merge
		for (int i = 0; i < ram_words; i++)
			ram_write_check(i, $urandom, strb_width'($urandom));
		for (int i = 0; i < ram_words; i++)
			ram_read_check(i);

		// Fill the mailbox, overflow once, drain and underflow once
		for (int i = 0; i < fifo_depth; i++)
			mbox_push_check($urandom);
		mbox_count_check();
		mbox_push_check($urandom);
		mbox_count_check();
		for (int i = 0; i < fifo_depth; i++)
			mbox_pop_check();
		mbox_pop_check();
		mbox_count_check();

		// Unowned addresses, RAM must stay untouched
		apb_write(outside_addr, $urandom, '1, err);
		expect_rsp("write outside window", err, 1'b1, 1'b0, '0, '0);
		apb_read(outside_addr, data, err);
		expect_rsp("read outside window", err, 1'b1, 1'b0, data, '0);
		apb_write(ram_base + 'h10, $urandom, '1, err);
		expect_rsp("ram write past end", err, 1'b1, 1'b0, '0, '0);
		apb_read(ram_base + 'h10, data, err);
		expect_rsp("ram read past end", err, 1'b1, 1'b0, data, '0);
		for (int i = 0; i < ram_words; i++)
			ram_read_check(i);

		// Random mix over both peripherals
		for (int n = 0; n < num_random; n++) begin
			case ($urandom_range(0, 4))
				0: ram_write_check($urandom_range(0, ram_words - 1), $urandom,
					strb_width'($urandom));
				1: ram_read_check($urandom_range(0, ram_words - 1));
				2: mbox_push_check($urandom);
				3: mbox_pop_check();
				default: mbox_count_check();
			endcase
		end

		if (dut.u_props.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			report_failure("a bound protocol assertion failed during the run");
		end
	end

endmodule

// File: apb_subsys_top.f
source/apb_pkg.sv
source/apb_req_slice.sv
source/apb_bridge.sv
source/apb_scratch_ram.sv
source/apb_mailbox.sv
source/apb_subsys_top.sv
bench/apb_subsys_properties.sv
bench/apb_subsys_tb.sv
